// File: source/dbg_trig_pkg.sv
`default_nettype none

package dbg_trig_pkg;

  //////////////////////////////
  // Configuration and types
  //////////////////////////////

  localparam int NUM_TRIGGERS = 4;       // Hardware triggers in the unit

  typedef logic [31:0] tdata_t;          // CSR word
  typedef logic [1:0]  privlvl_t;        // Privilege level

  localparam privlvl_t PRIV_LVL_M = 2'b11;  // Machine mode
  localparam privlvl_t PRIV_LVL_U = 2'b00;  // User mode

  // Trigger type codes in tdata1[31:28]
  localparam logic [3:0] TTYPE_MCONTROL6 = 4'h6;
  localparam logic [3:0] TTYPE_ETRIGGER  = 4'h5;
  localparam logic [3:0] TTYPE_DISABLED  = 4'hF;

  //////////////////////////////
  // tdata1 field positions
  //////////////////////////////

  localparam int TDATA1_TTYPE_HIGH = 31;
  localparam int TDATA1_TTYPE_LOW  = 28;

  localparam int MCONTROL6_MATCH_HIGH = 10;
  localparam int MCONTROL6_MATCH_LOW  = 7;
  localparam int MCONTROL6_M          = 6;   // Match in machine mode
  localparam int MCONTROL6_U          = 3;   // Match in user mode
  localparam int MCONTROL6_EXECUTE    = 2;
  localparam int MCONTROL6_STORE      = 1;
  localparam int MCONTROL6_LOAD       = 0;

  localparam int ETRIGGER_M = 9;
  localparam int ETRIGGER_U = 6;

  // Address compare modes
  localparam logic [3:0] MATCH_EQ = 4'h0;
  localparam logic [3:0] MATCH_GE = 4'h2;
  localparam logic [3:0] MATCH_LT = 4'h3;

  // Exception codes 0,1,2,3,5,7,11,24,25
  localparam tdata_t ETRIGGER_TDATA2_MASK = 32'h0300_08AF;

  // Disabled trigger, dmode set
  localparam tdata_t TDATA1_RST_VAL = 32'hF800_0000;

  // WARL for the match field, only EQ, GE and LT exist
  function automatic logic [3:0] match_resolve(logic [3:0] match);
    logic [3:0] resolved;
    resolved = MATCH_EQ;                 // Anything unsupported reads as EQ
    if ((match == MATCH_GE) || (match == MATCH_LT)) begin
      resolved = match;
    end
    return resolved;
  endfunction

endpackage

`default_nettype wire

// File: source/dbg_trig_lsu_span.sv
`timescale 1ns/100ps
`default_nettype none

module dbg_trig_lsu_span (
  input  dbg_trig_pkg::tdata_t lsu_addr_ex_i,    // Access address
  input  logic [3:0]           lsu_be_ex_i,      // Byte enables
  output dbg_trig_pkg::tdata_t lsu_addr_low_o,   // Lowest accessed byte
  output dbg_trig_pkg::tdata_t lsu_addr_high_o   // Highest accessed byte
);

  logic [1:0] low_lsb;
  logic [1:0] high_lsb;

  always_comb begin
    low_lsb  = 2'b00;                   // No enable gives byte 0
    high_lsb = 2'b00;
    // Upward scan, last hit is the top byte
    for (int b = 0; b < 4; b++) begin
      if (lsu_be_ex_i[b]) begin
        high_lsb = 2'(b);
      end
    end
    // Downward scan, last hit is the bottom byte
    for (int b = 3; b >= 0; b--) begin
      if (lsu_be_ex_i[b]) begin
        low_lsb = 2'(b);
      end
    end
  end

  assign lsu_addr_low_o  = {lsu_addr_ex_i[31:2], low_lsb};
  assign lsu_addr_high_o = {lsu_addr_ex_i[31:2], high_lsb};

endmodule

`default_nettype wire

// File: source/dbg_trig_match.sv
`timescale 1ns/100ps
`default_nettype none

module dbg_trig_match (
  // Stored CSRs of this trigger
  input  dbg_trig_pkg::tdata_t   tdata1_i,
  input  dbg_trig_pkg::tdata_t   tdata2_i,
  input  logic                   debug_mode_i,

  // IF stage
  input  dbg_trig_pkg::tdata_t   pc_if_i,
  input  logic                   ptr_in_if_i,
  input  dbg_trig_pkg::privlvl_t priv_lvl_if_i,

  // EX stage
  input  dbg_trig_pkg::privlvl_t priv_lvl_ex_i,
  input  logic                   lsu_valid_ex_i,
  input  logic                   lsu_we_ex_i,
  input  dbg_trig_pkg::tdata_t   lsu_addr_ex_i,
  input  dbg_trig_pkg::tdata_t   lsu_addr_low_i,
  input  dbg_trig_pkg::tdata_t   lsu_addr_high_i,
  input  logic [3:0]             lsu_be_ex_i,

  // WB stage
  input  dbg_trig_pkg::privlvl_t priv_lvl_wb_i,
  input  logic                   exception_in_wb_i,
  input  logic [10:0]            exception_cause_wb_i,

  output logic                   match_if_o,
  output logic                   match_ex_o,
  output logic                   etrigger_wb_o
);

  import dbg_trig_pkg::*;

  logic [3:0] ttype;
  logic [3:0] match_mode;
  logic       is_mcontrol6;
  logic       is_etrigger;
  logic       priv_en_if;                // Privilege qualifiers per stage
  logic       priv_en_ex;
  logic       priv_en_wb;
  logic       if_addr_match;
  logic [3:0] lsu_byte_match;            // Enabled byte sits at tdata2[1:0]
  logic       lsu_addr_match;
  logic       lsu_access_en;
  logic       exc_cause_match;

  assign ttype        = tdata1_i[TDATA1_TTYPE_HIGH:TDATA1_TTYPE_LOW];
  assign match_mode   = tdata1_i[MCONTROL6_MATCH_HIGH:MCONTROL6_MATCH_LOW];
  assign is_mcontrol6 = (ttype == TTYPE_MCONTROL6);
  assign is_etrigger  = (ttype == TTYPE_ETRIGGER);

  //////////////////////////////
  // Instruction address (IF)
  //////////////////////////////

  always_comb begin
    case (match_mode)
      MATCH_EQ: if_addr_match = (pc_if_i == tdata2_i);
      MATCH_GE: if_addr_match = (pc_if_i >= tdata2_i);
      MATCH_LT: if_addr_match = (pc_if_i <  tdata2_i);
      default:  if_addr_match = 1'b0;
    endcase
  end

  assign priv_en_if = (tdata1_i[MCONTROL6_M] && (priv_lvl_if_i == PRIV_LVL_M)) ||
                      (tdata1_i[MCONTROL6_U] && (priv_lvl_if_i == PRIV_LVL_U));

  // Table and pointer fetches never trigger
  assign match_if_o = is_mcontrol6 && tdata1_i[MCONTROL6_EXECUTE] && priv_en_if &&
                      !ptr_in_if_i && if_addr_match && !debug_mode_i;

  //////////////////////////////
  // Load/store address (EX)
  //////////////////////////////

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      lsu_byte_match[b] = lsu_be_ex_i[b] && (2'(b) == tdata2_i[1:0]);
    end
  end

  // EQ needs same word plus a hit byte, GE uses top byte, LT bottom byte
  always_comb begin
    case (match_mode)
      MATCH_EQ: lsu_addr_match = (lsu_addr_ex_i[31:2] == tdata2_i[31:2]) && (|lsu_byte_match);
      MATCH_GE: lsu_addr_match = (lsu_addr_high_i >= tdata2_i);
      MATCH_LT: lsu_addr_match = (lsu_addr_low_i  <  tdata2_i);
      default:  lsu_addr_match = 1'b0;
    endcase
  end

  assign priv_en_ex = (tdata1_i[MCONTROL6_M] && (priv_lvl_ex_i == PRIV_LVL_M)) ||
                      (tdata1_i[MCONTROL6_U] && (priv_lvl_ex_i == PRIV_LVL_U));

  assign lsu_access_en = lsu_valid_ex_i &&
                         ((tdata1_i[MCONTROL6_LOAD]  && !lsu_we_ex_i) ||
                          (tdata1_i[MCONTROL6_STORE] &&  lsu_we_ex_i));

  assign match_ex_o = is_mcontrol6 && priv_en_ex && lsu_access_en && lsu_addr_match &&
                      !debug_mode_i;

  //////////////////////////////
  // Exception trigger (WB)
  //////////////////////////////

  // Only causes below 32 map onto tdata2 bits
  assign exc_cause_match = (exception_cause_wb_i[10:5] == 6'd0) &&
                           tdata2_i[exception_cause_wb_i[4:0]];

  assign priv_en_wb = (tdata1_i[ETRIGGER_M] && (priv_lvl_wb_i == PRIV_LVL_M)) ||
                      (tdata1_i[ETRIGGER_U] && (priv_lvl_wb_i == PRIV_LVL_U));

  assign etrigger_wb_o = is_etrigger && exception_in_wb_i && exc_cause_match && priv_en_wb &&
                         !debug_mode_i;

endmodule

`default_nettype wire

// File: source/dbg_trig_csr.sv
`timescale 1ns/100ps
`default_nettype none

module dbg_trig_csr (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // CSR write side
  input  dbg_trig_pkg::tdata_t csr_wdata_i,
  input  logic                 tselect_we_i,
  input  logic                 tdata1_we_i,
  input  logic                 tdata2_we_i,

  // CSR read side, selected trigger
  output dbg_trig_pkg::tdata_t tselect_rdata_o,
  output dbg_trig_pkg::tdata_t tdata1_rdata_o,
  output dbg_trig_pkg::tdata_t tdata2_rdata_o,

  // Raw storage towards the match units
  output dbg_trig_pkg::tdata_t tdata1_q_o [dbg_trig_pkg::NUM_TRIGGERS],
  output dbg_trig_pkg::tdata_t tdata2_q_o [dbg_trig_pkg::NUM_TRIGGERS]
);

  import dbg_trig_pkg::*;

  tdata_t     tselect_q;                  // Trigger index
  tdata_t     tdata1_q [NUM_TRIGGERS];
  tdata_t     tdata2_q [NUM_TRIGGERS];

  tdata_t     sel_tdata1;                 // Registers of selected trigger
  tdata_t     sel_tdata2;
  tdata_t     tdata1_n;                   // WARL resolved write values
  tdata_t     tdata2_n;

  logic [3:0] wr_ttype;                   // Type field of the write data
  logic [3:0] sel_ttype;                  // Stored type of selected trigger
  logic       tselect_legal;
  logic       etrig_tdata2_ok;            // Stored tdata2 fits etrigger

  //////////////////////////////
  // tselect
  //////////////////////////////

  assign tselect_legal = (csr_wdata_i < tdata_t'(NUM_TRIGGERS));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tselect_q <= '0;
    end else if (tselect_we_i && tselect_legal) begin
      tselect_q <= csr_wdata_i;           // Out of range writes are dropped
    end
  end

  //////////////////////////////
  // Read multiplexer
  //////////////////////////////

  always_comb begin
    sel_tdata1 = tdata1_q[0];
    sel_tdata2 = tdata2_q[0];
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      if (tselect_q == tdata_t'(i)) begin
        sel_tdata1 = tdata1_q[i];
        sel_tdata2 = tdata2_q[i];
      end
    end
  end

  assign sel_ttype = sel_tdata1[TDATA1_TTYPE_HIGH:TDATA1_TTYPE_LOW];
  assign wr_ttype  = csr_wdata_i[TDATA1_TTYPE_HIGH:TDATA1_TTYPE_LOW];

  //////////////////////////////
  // WARL write resolution
  //////////////////////////////

  // Etrigger needs every enabled cause to be implemented, checked on the old tdata2
  assign etrig_tdata2_ok = ~|(sel_tdata2 & ~ETRIGGER_TDATA2_MASK);

  always_comb begin
    tdata1_n = TDATA1_RST_VAL;            // Unknown or illegal types end up disabled
    if (wr_ttype == TTYPE_MCONTROL6) begin
      tdata1_n = {
        TTYPE_MCONTROL6,                  // Type
        1'b1,                             // Dmode
        11'b0,                            // Uncertain, hit, select, timing, size
        4'b0001,                          // Action, enter debug
        1'b0,                             // Chain
        match_resolve(csr_wdata_i[MCONTROL6_MATCH_HIGH:MCONTROL6_MATCH_LOW]),
        csr_wdata_i[MCONTROL6_M],
        2'b00,                            // S and reserved
        csr_wdata_i[MCONTROL6_U],
        csr_wdata_i[MCONTROL6_EXECUTE],
        csr_wdata_i[MCONTROL6_STORE],
        csr_wdata_i[MCONTROL6_LOAD]
      };
    end else if ((wr_ttype == TTYPE_ETRIGGER) && etrig_tdata2_ok) begin
      tdata1_n = {
        TTYPE_ETRIGGER,                   // Type
        1'b1,                             // Dmode
        17'b0,                            // Hit, vs, vu and reserved
        csr_wdata_i[ETRIGGER_M],
        2'b00,                            // Reserved, S
        csr_wdata_i[ETRIGGER_U],
        6'b000001                         // Action, enter debug
      };
    end
  end

  // Exception trigger keeps only implemented causes
  assign tdata2_n = (sel_ttype == TTYPE_ETRIGGER) ? (csr_wdata_i & ETRIGGER_TDATA2_MASK) :
                                                    csr_wdata_i;

  //////////////////////////////
  // Per-trigger storage
  //////////////////////////////

  for (genvar t = 0; t < NUM_TRIGGERS; t++) begin : g_trig
    logic tdata1_we;                      // Write hits this trigger
    logic tdata2_we;

    assign tdata1_we = tdata1_we_i && (tselect_q == tdata_t'(t));
    assign tdata2_we = tdata2_we_i && (tselect_q == tdata_t'(t));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        tdata1_q[t] <= TDATA1_RST_VAL;
        tdata2_q[t] <= '0;
      end else begin
        if (tdata1_we) begin
          tdata1_q[t] <= tdata1_n;
        end
        if (tdata2_we) begin
          tdata2_q[t] <= tdata2_n;
        end
      end
    end
  end

  assign tselect_rdata_o = tselect_q;
  assign tdata1_rdata_o  = sel_tdata1;
  assign tdata2_rdata_o  = sel_tdata2;
  assign tdata1_q_o      = tdata1_q;
  assign tdata2_q_o      = tdata2_q;

endmodule

`default_nettype wire

// File: source/dbg_triggers.sv
`timescale 1ns/100ps
`default_nettype none

module dbg_triggers (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  // CSR access
  input  dbg_trig_pkg::tdata_t   csr_wdata_i,
  input  logic                   tselect_we_i,
  input  logic                   tdata1_we_i,
  input  logic                   tdata2_we_i,
  output dbg_trig_pkg::tdata_t   tselect_rdata_o,
  output dbg_trig_pkg::tdata_t   tdata1_rdata_o,
  output dbg_trig_pkg::tdata_t   tdata2_rdata_o,

  // IF stage
  input  dbg_trig_pkg::tdata_t   pc_if_i,
  input  logic                   ptr_in_if_i,
  input  dbg_trig_pkg::privlvl_t priv_lvl_if_i,

  // EX stage
  input  logic                   lsu_valid_ex_i,
  input  dbg_trig_pkg::tdata_t   lsu_addr_ex_i,
  input  logic                   lsu_we_ex_i,
  input  logic [3:0]             lsu_be_ex_i,
  input  dbg_trig_pkg::privlvl_t priv_lvl_ex_i,

  // WB stage
  input  dbg_trig_pkg::privlvl_t priv_lvl_wb_i,
  input  logic                   exception_in_wb_i,
  input  logic [10:0]            exception_cause_wb_i,

  input  logic                   debug_mode_i,

  output logic                   trigger_match_if_o,   // Instruction address hit
  output logic                   trigger_match_ex_o,   // Load/store address hit
  output logic                   etrigger_wb_o         // Exception hit
);

  import dbg_trig_pkg::*;

  tdata_t                  tdata1_q [NUM_TRIGGERS];
  tdata_t                  tdata2_q [NUM_TRIGGERS];
  tdata_t                  lsu_addr_low;
  tdata_t                  lsu_addr_high;
  logic [NUM_TRIGGERS-1:0] match_if;      // Per-trigger strobes
  logic [NUM_TRIGGERS-1:0] match_ex;
  logic [NUM_TRIGGERS-1:0] etrig_wb;

  dbg_trig_csr u_csr (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .csr_wdata_i     (csr_wdata_i),
    .tselect_we_i    (tselect_we_i),
    .tdata1_we_i     (tdata1_we_i),
    .tdata2_we_i     (tdata2_we_i),
    .tselect_rdata_o (tselect_rdata_o),
    .tdata1_rdata_o  (tdata1_rdata_o),
    .tdata2_rdata_o  (tdata2_rdata_o),
    .tdata1_q_o      (tdata1_q),
    .tdata2_q_o      (tdata2_q)
  );

  // Byte span is shared by all triggers
  dbg_trig_lsu_span u_span (
    .lsu_addr_ex_i   (lsu_addr_ex_i),
    .lsu_be_ex_i     (lsu_be_ex_i),
    .lsu_addr_low_o  (lsu_addr_low),
    .lsu_addr_high_o (lsu_addr_high)
  );

  for (genvar t = 0; t < NUM_TRIGGERS; t++) begin : g_match
    dbg_trig_match u_match (
      .tdata1_i             (tdata1_q[t]),
      .tdata2_i             (tdata2_q[t]),
      .debug_mode_i         (debug_mode_i),
      .pc_if_i              (pc_if_i),
      .ptr_in_if_i          (ptr_in_if_i),
      .priv_lvl_if_i        (priv_lvl_if_i),
      .priv_lvl_ex_i        (priv_lvl_ex_i),
      .lsu_valid_ex_i       (lsu_valid_ex_i),
      .lsu_we_ex_i          (lsu_we_ex_i),
      .lsu_addr_ex_i        (lsu_addr_ex_i),
      .lsu_addr_low_i       (lsu_addr_low),
      .lsu_addr_high_i      (lsu_addr_high),
      .lsu_be_ex_i          (lsu_be_ex_i),
      .priv_lvl_wb_i        (priv_lvl_wb_i),
      .exception_in_wb_i    (exception_in_wb_i),
      .exception_cause_wb_i (exception_cause_wb_i),
      .match_if_o           (match_if[t]),
      .match_ex_o           (match_ex[t]),
      .etrigger_wb_o        (etrig_wb[t])
    );
  end

  // Any trigger fires the stage strobe
  assign trigger_match_if_o = |match_if;
  assign trigger_match_ex_o = |match_ex;
  assign etrigger_wb_o      = |etrig_wb;

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 40 ns period, 20 ns per phase
  initial begin
    clk_o = 1'b0;
    forever begin
      #20 clk_o = ~clk_o;
    end
  end

  // Reset low over two rising edges, released just after the second
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    #2 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: sim/dbg_triggers_checker.sv
`timescale 1ns/100ps
`default_nettype none

module dbg_triggers_checker (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 debug_mode_i,
  input  dbg_trig_pkg::tdata_t tselect_rdata_i,
  input  logic                 trigger_match_if_i,
  input  logic                 trigger_match_ex_i,
  input  logic                 etrigger_wb_i
);

  import dbg_trig_pkg::*;

  logic [2:0] strobes;                  // IF, EX, WB

  assign strobes = {trigger_match_if_i, trigger_match_ex_i, etrigger_wb_i};

  //////////////////////////////
  // Port properties
  //////////////////////////////

  // A halted core never sees a trigger
  debug_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    debug_mode_i |-> (strobes == 3'b000))
    else $error("Trigger strobe active in debug mode");

  tselect_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tselect_rdata_i < tdata_t'(NUM_TRIGGERS))   // WARL keeps index legal
    else $error("tselect out of range, value %h", tselect_rdata_i);

  strobes_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(strobes))
    else $error("Trigger strobe unknown after reset");

endmodule

`default_nettype wire

// File: sim/dbg_triggers_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dbg_triggers_tb;

  import dbg_trig_pkg::*;

  logic        clk;
  logic        rst_n;

  // DUT inputs
  tdata_t      csr_wdata;
  logic        tselect_we;
  logic        tdata1_we;
  logic        tdata2_we;
  tdata_t      pc_if;
  logic        ptr_in_if;
  privlvl_t    priv_lvl_if;
  logic        lsu_valid_ex;
  tdata_t      lsu_addr_ex;
  logic        lsu_we_ex;
  logic [3:0]  lsu_be_ex;
  privlvl_t    priv_lvl_ex;
  privlvl_t    priv_lvl_wb;
  logic        exception_in_wb;
  logic [10:0] exception_cause_wb;
  logic        debug_mode;

  // DUT outputs
  tdata_t      tselect_rdata;
  tdata_t      tdata1_rdata;
  tdata_t      tdata2_rdata;
  logic        trigger_match_if;
  logic        trigger_match_ex;
  logic        etrigger_wb;

  // Reference model of the CSRs
  tdata_t      m_tselect;
  tdata_t      m_tdata1 [NUM_TRIGGERS];
  tdata_t      m_tdata2 [NUM_TRIGGERS];

  logic [31:0] rng_state = 32'h5ad9;   // LCG state
  int          debug_left;             // Cycles left in the current debug stretch

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  dbg_triggers dut (
    .clk_i                (clk),
    .rst_n_i              (rst_n),
    .csr_wdata_i          (csr_wdata),
    .tselect_we_i         (tselect_we),
    .tdata1_we_i          (tdata1_we),
    .tdata2_we_i          (tdata2_we),
    .tselect_rdata_o      (tselect_rdata),
    .tdata1_rdata_o       (tdata1_rdata),
    .tdata2_rdata_o       (tdata2_rdata),
    .pc_if_i              (pc_if),
    .ptr_in_if_i          (ptr_in_if),
    .priv_lvl_if_i        (priv_lvl_if),
    .lsu_valid_ex_i       (lsu_valid_ex),
    .lsu_addr_ex_i        (lsu_addr_ex),
    .lsu_we_ex_i          (lsu_we_ex),
    .lsu_be_ex_i          (lsu_be_ex),
    .priv_lvl_ex_i        (priv_lvl_ex),
    .priv_lvl_wb_i        (priv_lvl_wb),
    .exception_in_wb_i    (exception_in_wb),
    .exception_cause_wb_i (exception_cause_wb),
    .debug_mode_i         (debug_mode),
    .trigger_match_if_o   (trigger_match_if),
    .trigger_match_ex_o   (trigger_match_ex),
    .etrigger_wb_o        (etrigger_wb)
  );

  bind dbg_triggers dbg_triggers_checker u_checker (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .debug_mode_i       (debug_mode_i),
    .tselect_rdata_i    (tselect_rdata_o),
    .trigger_match_if_i (trigger_match_if_o),
    .trigger_match_ex_i (trigger_match_ex_o),
    .etrigger_wb_i      (etrigger_wb_o)
  );

  //////////////////////////////
  // Random numbers and model
  //////////////////////////////

  function automatic logic [31:0] lcg_next();
    logic [31:0] first;
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    first     = rng_state;
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {first[31:16], rng_state[31:16]};   // Upper halves only, low bits cycle fast
  endfunction

  function automatic logic priv_ok(logic en_m, logic en_u, privlvl_t priv);
    return (en_m && (priv == 2'b11)) || (en_u && (priv == 2'b00));
  endfunction

  // tdata1 WARL result built field by field
  function automatic tdata_t warl_tdata1(tdata_t wdata, tdata_t old_tdata2);
    tdata_t word;
    word = TDATA1_RST_VAL;                    // Disabled unless a legal type
    if (wdata[31:28] == 4'h6) begin
      word      = 32'h6800_1000;              // Type 6, dmode, action 1
      if ((wdata[10:7] == 4'h2) || (wdata[10:7] == 4'h3)) begin
        word[10:7] = wdata[10:7];
      end
      word[6]   = wdata[6];                   // M
      word[3:0] = wdata[3:0];                 // U, execute, store, load
    end else if ((wdata[31:28] == 4'h5) && ((old_tdata2 & ~ETRIGGER_TDATA2_MASK) == '0)) begin
      word    = 32'h5800_0001;                // Type 5, dmode, action 1
      word[9] = wdata[9];
      word[6] = wdata[6];
    end
    return word;
  endfunction

  // Edge update, both tdata rules see the old values
  task automatic update_model();
    int     sel;
    tdata_t new_t1;
    tdata_t new_t2;
    sel    = int'(m_tselect);
    new_t1 = warl_tdata1(csr_wdata, m_tdata2[sel]);
    new_t2 = (m_tdata1[sel][31:28] == 4'h5) ? (csr_wdata & ETRIGGER_TDATA2_MASK) : csr_wdata;
    if (tdata1_we) begin
      m_tdata1[sel] = new_t1;
    end
    if (tdata2_we) begin
      m_tdata2[sel] = new_t2;
    end
    if (tselect_we && (csr_wdata < tdata_t'(NUM_TRIGGERS))) begin
      m_tselect = csr_wdata;
    end
  endtask

  // Expected strobes {WB, EX, IF}
  function automatic logic [2:0] expected_strobes();
    logic [2:0] hits;
    tdata_t     t1;
    tdata_t     t2;
    logic [1:0] lo;
    logic [1:0] hi;
    logic       hit;
    hits = 3'b000;
    lo = lsu_be_ex[0] ? 2'd0 : lsu_be_ex[1] ? 2'd1 :
         lsu_be_ex[2] ? 2'd2 : lsu_be_ex[3] ? 2'd3 : 2'd0;
    hi = lsu_be_ex[3] ? 2'd3 : lsu_be_ex[2] ? 2'd2 : lsu_be_ex[1] ? 2'd1 : 2'd0;
    for (int t = 0; t < NUM_TRIGGERS; t++) begin
      t1 = m_tdata1[t];
      t2 = m_tdata2[t];
      if (t1[31:28] == 4'h6) begin
        case (t1[10:7])
          4'h2:    hit = (pc_if >= t2);
          4'h3:    hit = (pc_if < t2);
          default: hit = (pc_if == t2);
        endcase
        if (hit && t1[2] && !ptr_in_if && priv_ok(t1[6], t1[3], priv_lvl_if)) begin
          hits[0] = 1'b1;
        end
        case (t1[10:7])
          4'h2:    hit = ({lsu_addr_ex[31:2], hi} >= t2);   // Top byte of the access
          4'h3:    hit = ({lsu_addr_ex[31:2], lo} < t2);    // Bottom byte
          default: hit = (lsu_addr_ex[31:2] == t2[31:2]) && lsu_be_ex[t2[1:0]];
        endcase
        if (hit && lsu_valid_ex && (lsu_we_ex ? t1[1] : t1[0]) &&
            priv_ok(t1[6], t1[3], priv_lvl_ex)) begin
          hits[1] = 1'b1;
        end
      end
      if ((t1[31:28] == 4'h5) && exception_in_wb && (exception_cause_wb < 11'd32) &&
          t2[exception_cause_wb[4:0]] && priv_ok(t1[9], t1[6], priv_lvl_wb)) begin
        hits[2] = 1'b1;
      end
    end
    if (debug_mode) begin
      hits = 3'b000;
    end
    return hits;
  endfunction

  //////////////////////////////
  // Stimulus and checks
  //////////////////////////////

  task automatic init_inputs();
    csr_wdata          = '0;
    tselect_we         = 1'b0;
    tdata1_we          = 1'b0;
    tdata2_we          = 1'b0;
    pc_if              = '0;
    ptr_in_if          = 1'b0;
    priv_lvl_if        = 2'b00;
    lsu_valid_ex       = 1'b0;
    lsu_addr_ex        = '0;
    lsu_we_ex          = 1'b0;
    lsu_be_ex          = 4'h0;
    priv_lvl_ex        = 2'b00;
    priv_lvl_wb        = 2'b00;
    exception_in_wb    = 1'b0;
    exception_cause_wb = '0;
    debug_mode         = 1'b0;
    debug_left         = 0;
    m_tselect          = '0;
    for (int t = 0; t < NUM_TRIGGERS; t++) begin
      m_tdata1[t] = TDATA1_RST_VAL;
      m_tdata2[t] = '0;
    end
  endtask

  task automatic drive_random();
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    r = lcg_next();
    a = lcg_next();
    b = lcg_next();
    c = lcg_next();
    tselect_we = 1'b0;
    tdata1_we  = 1'b0;
    tdata2_we  = 1'b0;
    csr_wdata  = a;
    case (r[3:0])
      4'd0, 4'd1: begin
        tselect_we = 1'b1;
        tdata1_we  = r[5] && r[6];              // Old tselect still names the target
        tdata2_we  = r[5] && r[7];
        csr_wdata  = r[4] ? {29'h0, a[2:0]} : {30'h0, a[1:0]};   // Three bits reach past range
      end
      4'd2, 4'd3, 4'd4, 4'd8: begin
        tdata1_we = 1'b1;
        tdata2_we = (r[3:0] == 4'd8);           // Both in one cycle
        case (b[2:0])
          3'd0, 3'd1, 3'd2: csr_wdata[31:28] = 4'h6;
          3'd3, 3'd4:       csr_wdata[31:28] = 4'h5;
          3'd5:             csr_wdata[31:28] = 4'h2;   // Legacy mcontrol
          default:          csr_wdata[31:28] = a[31:28];
        endcase
        if (b[3]) begin
          csr_wdata[10:7] = {2'b00, b[5:4]};    // Mostly supported match codes
        end
      end
      4'd5, 4'd6, 4'd7: begin
        tdata2_we = 1'b1;
        case (b[1:0])
          2'd0, 2'd1: csr_wdata = 32'h0000_1000 | {26'h0, a[5:0]};   // Address window
          2'd2:       csr_wdata = a & ETRIGGER_TDATA2_MASK;
          default:    csr_wdata = a;
        endcase
      end
      default: ;                                // No write this cycle
    endcase
    pc_if              = 32'h0000_1000 | {25'h0, b[12:6]};
    ptr_in_if          = (b[15:13] == 3'd0);
    priv_lvl_if        = b[17:16];
    lsu_valid_ex       = (b[19:18] != 2'd0);
    lsu_addr_ex        = 32'h0000_1000 | {25'h0, b[26:20]};
    lsu_we_ex          = b[27];
    lsu_be_ex          = r[11:8];
    priv_lvl_ex        = b[29:28];
    priv_lvl_wb        = b[31:30];
    exception_in_wb    = c[0] | c[1];
    exception_cause_wb = 11'((c >> 2) % 32'd41);   // Causes 0 to 40
    if (debug_left == 0) begin
      debug_mode = (c[31:30] == 2'b11);
      debug_left = int'(c[29:25]) + 1;
    end
    debug_left--;
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  task automatic check_outputs();
    int         sel;
    logic [2:0] exp;
    sel = int'(m_tselect);
    exp = expected_strobes();
    check_value("tselect_rdata_o", tselect_rdata, m_tselect);
    check_value("tdata1_rdata_o", tdata1_rdata, m_tdata1[sel]);
    check_value("tdata2_rdata_o", tdata2_rdata, m_tdata2[sel]);
    check_value("trigger_match_if_o", 32'(trigger_match_if), 32'(exp[0]));
    check_value("trigger_match_ex_o", 32'(trigger_match_ex), 32'(exp[1]));
    check_value("etrigger_wb_o", 32'(etrigger_wb), 32'(exp[2]));
  endtask

  task automatic wait_reset();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      cycles++;
      if (cycles > 10) begin
        $display("Reset was not released within 10 clock cycles");
        $display("Regression failed");
        $fatal(1);
      end
    end
  endtask

  initial begin
    init_inputs();
    wait_reset();
    @(negedge clk);
    check_value("tselect_rdata_o", tselect_rdata, 32'h0000_0000);   // Reset values
    check_value("tdata1_rdata_o", tdata1_rdata, 32'hF800_0000);
    check_value("tdata2_rdata_o", tdata2_rdata, 32'h0000_0000);
    check_value("trigger_match_if_o", 32'(trigger_match_if), 32'h0);
    check_value("trigger_match_ex_o", 32'(trigger_match_ex), 32'h0);
    check_value("etrigger_wb_o", 32'(etrigger_wb), 32'h0);
    repeat (3000) begin
      @(posedge clk);
      update_model();                         // DUT samples the same inputs here
      #2;
      drive_random();
      @(negedge clk);
      check_outputs();
    end
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: dbg_triggers.f
source/dbg_trig_pkg.sv
source/dbg_trig_lsu_span.sv
source/dbg_trig_match.sv
source/dbg_trig_csr.sv
source/dbg_triggers.sv
sim/tb_clk_gen.sv
sim/dbg_triggers_checker.sv
sim/dbg_triggers_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the dbg_triggers regression with Verilator

TOP=dbg_triggers_tb
BUILD_DIR=obj_dir
LOG=sim.log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project root"
  exit 1
fi

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module "$TOP" --Mdir "$BUILD_DIR" -f dbg_triggers.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
